//--- verilog/fpm_settings.svh
// ----------------------------------------
// fpm sizing constants
// exponent, counter, mantissa and fault pulse
// ----------------------------------------

`ifndef FPM_SETTINGS_SVH
`define FPM_SETTINGS_SVH

// exponent byte and its guard bits
`define FPM_EXP_W 8
`define FPM_GUARD_W 2
`define FPM_D_W (`FPM_EXP_W + `FPM_GUARD_W)

// shift counter and mantissa length
`define FPM_CNT_W 6
`define FPM_MANT_W 40

// stretched fault pulse, in cycles
`define FPM_FI0_TICKS 4

`endif

//--- verilog/fpm_pkg.sv
// ----------------------------------------
// fpm shared types
// ----------------------------------------

package fpm_pkg;

	// encoded exactly as the instruction field
	typedef enum logic [2:0] {
		op_ad = 3'd0,
		op_sd = 3'd1,
		op_mw = 3'd2,
		op_dw = 3'd3,
		op_af = 3'd4,
		op_sf = 3'd5,
		op_mf = 3'd6,
		op_df = 3'd7
	} fpm_op_t;

	// b bus source selection
	typedef enum logic [1:0] {
		bm_inv  = 2'd0,
		bm_true = 2'd1,
		bm_ones = 2'd2,
		bm_zero = 2'd3
	} fpm_bmode_t;

	typedef struct packed {
		logic valid;
		logic addsub_f;
		logic muldiv_f;
		logic div;
		logic sub;
		logic fixed;
	} fpm_dec_t;

	typedef struct packed {
		logic c;
		logic v;
		logic m;
		logic z;
	} fpm_flags_t;

	typedef struct packed {
		logic fi0;
		logic fi1;
		logic fi2;
		logic fi3;
	} fpm_faults_t;

endpackage

//--- verilog/fpm_op_decode.sv
// ----------------------------------------
// fpm instruction decoder
// groups the op field into operation classes
// ----------------------------------------

module fpm_op_decode import fpm_pkg::*; (
	input  fpm_op_t  ir,
	input  logic     pufa,
	output fpm_dec_t dec
);

	always_comb begin
		dec = '0;
		// nothing is active outside an fp instruction
		if (pufa) begin
			dec.valid = 1'b1;
			case (ir)
				op_ad: begin
					dec.fixed = 1'b1;
				end
				op_sd: begin
					dec.fixed = 1'b1;
					dec.sub = 1'b1;
				end
				op_mw: begin
					dec.fixed = 1'b1;
				end
				op_dw: begin
					dec.fixed = 1'b1;
					dec.div = 1'b1;
				end
				op_af: begin
					dec.addsub_f = 1'b1;
				end
				op_sf: begin
					dec.addsub_f = 1'b1;
					dec.sub = 1'b1;
				end
				op_mf: begin
					dec.muldiv_f = 1'b1;
				end
				op_df: begin
					dec.muldiv_f = 1'b1;
					dec.div = 1'b1;
				end
				default: begin
					dec.valid = 1'b0;
				end
			endcase
		end
	end

endmodule

//--- verilog/fpm_exp_path.sv
// ----------------------------------------
// fpm exponent path
// l bus, d and b registers, guarded adder
// ----------------------------------------

`include "fpm_settings.svh"

module fpm_exp_path import fpm_pkg::*; (
	input  logic                  f2strob,
	input  logic                  reset,
	input  logic [`FPM_EXP_W-1:0] w,
	input  logic                  lkb,
	input  logic                  load_d,
	input  logic                  load_b,
	input  logic                  carry_in,
	input  fpm_bmode_t            b_mode,
	output logic [`FPM_D_W-1:0]   d,
	output logic [`FPM_D_W-1:0]   sum,
	output logic                  carry
);

	logic [`FPM_D_W-1:0]   l_bus;
	logic [`FPM_EXP_W-1:0] b_reg;
	logic [`FPM_D_W-1:0]   b_ext;
	logic [`FPM_D_W-1:0]   b_bus;
	logic [`FPM_EXP_W:0]   low_sum;

	// external byte gets its sign copied into the guard bits
	always_comb begin
		if (lkb) begin
			l_bus = {{`FPM_GUARD_W{w[`FPM_EXP_W-1]}}, w};
		end else begin
			l_bus = sum;
		end
	end

	always_ff @(posedge f2strob) begin
		if (reset) begin
			d <= '0;
		end else if (load_d) begin
			d <= l_bus;
		end
	end

	// b only keeps the byte part of d
	always_ff @(posedge f2strob) begin
		if (reset) begin
			b_reg <= '0;
		end else if (load_b) begin
			b_reg <= d[`FPM_EXP_W-1:0];
		end
	end

	assign b_ext = {{`FPM_GUARD_W{b_reg[`FPM_EXP_W-1]}}, b_reg};

	always_comb begin
		b_bus = '0;
		case (b_mode)
			bm_inv: begin
				b_bus = ~b_ext;
			end
			bm_true: begin
				b_bus = b_ext;
			end
			bm_ones: begin
				b_bus = '1;
			end
			bm_zero: begin
				b_bus = '0;
			end
			default: begin
				b_bus = '0;
			end
		endcase
	end

	// guard bits keep exponent overflow visible
	assign sum = b_bus + d + {{(`FPM_D_W-1){1'b0}}, carry_in};

	// carry out of the byte part only
	assign low_sum = {1'b0, b_bus[`FPM_EXP_W-1:0]}
		+ {1'b0, d[`FPM_EXP_W-1:0]}
		+ {{`FPM_EXP_W{1'b0}}, carry_in};
	assign carry = low_sum[`FPM_EXP_W];

endmodule

//--- verilog/fpm_shift_count.sv
// ----------------------------------------
// fpm alignment and shift counter
// ----------------------------------------

`include "fpm_settings.svh"

module fpm_shift_count import fpm_pkg::*; (
	input  logic                  f2strob,
	input  logic                  reset,
	input  logic                  clear_f,
	input  logic                  align,
	input  logic                  shift,
	input  fpm_dec_t              dec,
	input  logic [`FPM_D_W-1:0]   sum,
	output logic                  g,
	output logic                  wdt,
	output logic [`FPM_CNT_W-1:0] fic,
	output logic                  fic_zero
);

	localparam logic [`FPM_D_W-1:0]   MANT_D   = `FPM_MANT_W;
	localparam logic [`FPM_CNT_W-1:0] MANT_CNT = `FPM_MANT_W;

	logic [`FPM_D_W-1:0] mag;
	logic                too_far;

	// exponent difference magnitude
	assign mag = sum[`FPM_D_W-1] ? -sum : sum;
	assign too_far = mag >= MANT_D;

	assign fic_zero = fic == '0;

	always_ff @(posedge f2strob) begin
		if (reset || clear_f) begin
			g <= 1'b0;
			wdt <= 1'b0;
			fic <= '0;
		end else if (align && dec.addsub_f) begin
			wdt <= sum[`FPM_D_W-1];
			g <= too_far;
			fic <= too_far ? MANT_CNT : mag[`FPM_CNT_W-1:0];
		end else if (align && dec.muldiv_f) begin
			// one step per mantissa bit
			g <= 1'b0;
			fic <= MANT_CNT;
		end else if (shift && !fic_zero) begin
			fic <= fic - 1'b1;
		end
	end

endmodule

//--- verilog/fpm_flags.sv
// ----------------------------------------
// fpm status flags c, v, m and z
// ----------------------------------------

`include "fpm_settings.svh"

module fpm_flags import fpm_pkg::*; (
	input  logic                f2strob,
	input  logic                reset,
	input  logic                clear_f,
	input  logic                align,
	input  fpm_dec_t            dec,
	input  logic [`FPM_D_W-1:0] sum,
	input  logic                carry,
	input  logic                mant_zero,
	output fpm_flags_t          flags
);

	fpm_flags_t next;

	always_comb begin
		next.c = carry;
		// guard bits must repeat the byte sign
		next.v = sum[`FPM_D_W-1:`FPM_EXP_W] != {`FPM_GUARD_W{sum[`FPM_EXP_W-1]}};
		next.m = sum[`FPM_D_W-1];
		// floating result is zero when the mantissa is
		next.z = (sum == '0) || (!dec.fixed && mant_zero);
	end

	always_ff @(posedge f2strob) begin
		if (reset || clear_f) begin
			flags <= '0;
		end else if (align && dec.valid) begin
			flags <= next;
		end
	end

endmodule

//--- verilog/fpm_faults.sv
// ----------------------------------------
// fpm fault indications
// sticky faults and stretched fi0 pulse
// ----------------------------------------

`include "fpm_settings.svh"

module fpm_faults import fpm_pkg::*; (
	input  logic                f2strob,
	input  logic                reset,
	input  logic                clear_f,
	input  logic                align,
	input  fpm_dec_t            dec,
	input  logic [`FPM_D_W-1:0] sum,
	input  logic                mant_zero,
	output fpm_faults_t         faults
);

	localparam int TICK_W = $clog2(`FPM_FI0_TICKS + 1);

	logic              fi1_q;
	logic              fi2_q;
	logic              fi3_q;
	logic [TICK_W-1:0] ticks;
	logic              out_of_range;
	logic              div_zero;

	// exponent no longer fits in a byte
	assign out_of_range =
		sum[`FPM_D_W-1:`FPM_EXP_W-1] != {(`FPM_GUARD_W+1){sum[`FPM_D_W-1]}};

	assign div_zero = align && dec.div && mant_zero;

	always_ff @(posedge f2strob) begin
		if (reset || clear_f) begin
			fi1_q <= 1'b0;
			fi2_q <= 1'b0;
			fi3_q <= 1'b0;
		end else begin
			if (align && dec.muldiv_f && out_of_range) begin
				fi1_q <= fi1_q | ~sum[`FPM_D_W-1];
				fi2_q <= fi2_q | sum[`FPM_D_W-1];
			end
			if (div_zero) begin
				fi3_q <= 1'b1;
			end
		end
	end

	// pulse starts on the edge that raises fi3
	always_ff @(posedge f2strob) begin
		if (reset || clear_f) begin
			ticks <= '0;
		end else if (div_zero && !fi3_q) begin
			ticks <= TICK_W'(`FPM_FI0_TICKS);
		end else if (ticks != '0) begin
			ticks <= ticks - 1'b1;
		end
	end

	assign faults = '{fi0: ticks != '0, fi1: fi1_q, fi2: fi2_q, fi3: fi3_q};

endmodule

//--- verilog/fpm.sv
// ----------------------------------------
// fpm exponent and sequencing slice
// ----------------------------------------

`include "fpm_settings.svh"

module fpm import fpm_pkg::*; (
	input  logic                  f2strob,
	input  logic                  reset,
	input  fpm_op_t               ir,
	input  logic                  pufa,
	input  logic [`FPM_EXP_W-1:0] w,
	input  logic                  lkb,
	input  logic                  load_d,
	input  logic                  load_b,
	input  fpm_bmode_t            b_mode,
	input  logic                  carry_in,
	input  logic                  align,
	input  logic                  shift,
	input  logic                  mant_zero,
	input  logic                  clear_f,
	output logic [`FPM_D_W-1:0]   d,
	output logic [`FPM_D_W-1:0]   sum,
	output logic                  g,
	output logic                  wdt,
	output logic [`FPM_CNT_W-1:0] fic,
	output logic                  fic_zero,
	output fpm_flags_t            flags,
	output fpm_faults_t           faults
);

	fpm_dec_t dec;
	logic     carry;

	fpm_op_decode op_decode_inst (
		.ir   (ir),
		.pufa (pufa),
		.dec  (dec)
	);

	fpm_exp_path exp_path_inst (
		.f2strob  (f2strob),
		.reset    (reset),
		.w        (w),
		.lkb      (lkb),
		.load_d   (load_d),
		.load_b   (load_b),
		.carry_in (carry_in),
		.b_mode   (b_mode),
		.d        (d),
		.sum      (sum),
		.carry    (carry)
	);

	fpm_shift_count shift_count_inst (
		.f2strob  (f2strob),
		.reset    (reset),
		.clear_f  (clear_f),
		.align    (align),
		.shift    (shift),
		.dec      (dec),
		.sum      (sum),
		.g        (g),
		.wdt      (wdt),
		.fic      (fic),
		.fic_zero (fic_zero)
	);

	fpm_flags flags_inst (
		.f2strob   (f2strob),
		.reset     (reset),
		.clear_f   (clear_f),
		.align     (align),
		.dec       (dec),
		.sum       (sum),
		.carry     (carry),
		.mant_zero (mant_zero),
		.flags     (flags)
	);

	fpm_faults faults_inst (
		.f2strob   (f2strob),
		.reset     (reset),
		.clear_f   (clear_f),
		.align     (align),
		.dec       (dec),
		.sum       (sum),
		.mant_zero (mant_zero),
		.faults    (faults)
	);

endmodule

//--- tb/fpm_chk.sv
// ----------------------------------------
// fpm checker
// counter, fault and clear rules
// ----------------------------------------

`include "fpm_settings.svh"

module fpm_chk import fpm_pkg::*; (
	input logic                  f2strob,
	input logic                  reset,
	input logic                  align,
	input logic                  clear_f,
	input logic [`FPM_CNT_W-1:0] fic,
	input logic                  fic_zero,
	input fpm_faults_t           faults
);

	int fail_count = 0;

	// the counter only goes up when align loads it
	assert property (@(posedge f2strob) disable iff (reset)
		!$past(align) |-> fic <= $past(fic))
		else begin
			fail_count++;
			$error("fic rose without align");
		end

	assert property (@(posedge f2strob) disable iff (reset)
		faults.fi0 |-> faults.fi3)
		else begin
			fail_count++;
			$error("fi0 high while fi3 low");
		end

	assert property (@(posedge f2strob) disable iff (reset)
		$past(clear_f) |-> faults == '0)
		else begin
			fail_count++;
			$error("faults still set after clear_f");
		end

	assert property (@(posedge f2strob) disable iff (reset)
		fic_zero == (fic == '0))
		else begin
			fail_count++;
			$error("fic_zero disagrees with fic");
		end

endmodule

bind fpm fpm_chk chk_inst (
	.f2strob  (f2strob),
	.reset    (reset),
	.align    (align),
	.clear_f  (clear_f),
	.fic      (fic),
	.fic_zero (fic_zero),
	.faults   (faults)
);

//--- tb/fpm_tb.sv
// ----------------------------------------
// fpm testbench
// directed tests of the exponent slice
// ----------------------------------------

`include "fpm_settings.svh"

module fpm_tb import fpm_pkg::*; ();

	logic f2strob = 1'b0;
	logic reset;
	fpm_op_t ir;
	logic pufa;
	logic lkb;
	logic load_d;
	logic load_b;
	logic carry_in;
	logic align;
	logic shift;
	logic mant_zero;
	logic clear_f;
	logic [`FPM_EXP_W-1:0] w;
	fpm_bmode_t b_mode;
	logic [`FPM_D_W-1:0] d;
	logic [`FPM_D_W-1:0] sum;
	logic g;
	logic wdt;
	logic fic_zero;
	logic [`FPM_CNT_W-1:0] fic;
	fpm_flags_t flags;
	fpm_faults_t faults;
	integer seed = 32'h234f;
	// expected register contents
	logic [`FPM_EXP_W-1:0] b_model;
	logic [`FPM_D_W-1:0] d_model;

	fpm fpm_inst (.*);

	always #2 f2strob = ~f2strob;

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped");
	endtask

	task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [`FPM_D_W-1:0] sext(input logic [`FPM_EXP_W-1:0] v);
		return {{`FPM_GUARD_W{v[`FPM_EXP_W-1]}}, v};
	endfunction

	function automatic logic [`FPM_D_W-1:0] bus_value(input fpm_bmode_t mode);
		case (mode)
			bm_inv: return ~sext(b_model);
			bm_true: return sext(b_model);
			bm_ones: return '1;
			default: return '0;
		endcase
	endfunction

	function automatic logic [`FPM_D_W-1:0] expect_sum(input fpm_bmode_t mode, input logic cin);
		return bus_value(mode) + d_model + cin;
	endfunction

	task automatic load_exp(input logic from_w, input logic [`FPM_EXP_W-1:0] v);
		logic [`FPM_D_W-1:0] nxt;
		nxt = from_w ? sext(v) : expect_sum(b_mode, carry_in);
		@(posedge f2strob);
		w <= v;
		lkb <= from_w;
		load_d <= 1'b1;
		@(posedge f2strob);
		load_d <= 1'b0;
		@(negedge f2strob);
		d_model = nxt;
		check_eq("d", d, d_model);
	endtask

	task automatic copy_b();
		@(posedge f2strob);
		load_b <= 1'b1;
		@(posedge f2strob);
		load_b <= 1'b0;
		@(negedge f2strob);
		b_model = d_model[`FPM_EXP_W-1:0];
	endtask

	task automatic prepare(input logic [`FPM_EXP_W-1:0] b_val, input logic [`FPM_EXP_W-1:0] d_val);
		load_exp(1'b1, b_val);
		copy_b();
		load_exp(1'b1, d_val);
	endtask

	task automatic set_bus(input fpm_bmode_t mode, input logic cin);
		@(posedge f2strob);
		b_mode <= mode;
		carry_in <= cin;
		@(negedge f2strob);
		check_eq("sum", sum, expect_sum(mode, cin));
	endtask

	task automatic pulse_align(input fpm_op_t op, input logic p, input logic mz);
		@(posedge f2strob);
		ir <= op;
		pufa <= p;
		mant_zero <= mz;
		align <= 1'b1;
		@(posedge f2strob);
		align <= 1'b0;
		pufa <= 1'b0;
		mant_zero <= 1'b0;
		@(negedge f2strob);
	endtask

	task automatic pulse_shift();
		@(posedge f2strob);
		shift <= 1'b1;
		@(posedge f2strob);
		shift <= 1'b0;
		@(negedge f2strob);
	endtask

	task automatic pulse_clear();
		@(posedge f2strob);
		clear_f <= 1'b1;
		@(posedge f2strob);
		clear_f <= 1'b0;
		@(negedge f2strob);
		check_eq("faults", faults, 4'h0);
		check_eq("flags", flags, 4'h0);
	endtask

	task automatic test_load_add();
		logic [31:0] r;
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			prepare(r[7:0], r[15:8]);
			for (int m = 0; m < 4; m++) begin
				set_bus(fpm_bmode_t'(m), 1'b0);
				set_bus(fpm_bmode_t'(m), 1'b1);
			end
			set_bus(bm_true, r[16]);
			load_exp(1'b0, 8'h00);
		end
	endtask

	task automatic test_align();
		logic [31:0] r;
		int da;
		int want;
		int n;
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			// even rounds keep the two exponents close
			if (i % 2 == 0) r[15:8] = r[7:0] + {2'b00, r[21:16]} - 8'd32;
			prepare(r[15:8], r[7:0]);
			set_bus(bm_inv, 1'b1);
			da = $signed(r[7:0]) - $signed(r[15:8]);
			want = (da < 0) ? -da : da;
			pulse_align((i % 2) ? op_sf : op_af, 1'b1, 1'b0);
			check_eq("wdt", wdt, da < 0);
			check_eq("g", g, want >= `FPM_MANT_W);
			if (want >= `FPM_MANT_W) want = `FPM_MANT_W;
			check_eq("fic", fic, want);
			n = 0;
			while (!fic_zero && n < 64) begin
				pulse_shift();
				n++;
			end
			if (!fic_zero) begin
				$display("timeout: fic_zero never rose while shifting");
				abort_run();
			end
			check_eq("shift_pulses", n, want);
		end
	endtask

	task automatic test_muldiv();
		prepare(8'h00, 8'h60);
		set_bus(bm_inv, 1'b1);
		pulse_align(op_af, 1'b1, 1'b0);
		check_eq("g", g, 1'b1);
		pulse_align(op_mf, 1'b1, 1'b0);
		check_eq("fic", fic, `FPM_MANT_W);
		check_eq("g", g, 1'b0);
		pulse_shift();
		pulse_shift();
		check_eq("fic", fic, `FPM_MANT_W - 2);
		pulse_align(op_df, 1'b1, 1'b0);
		check_eq("fic", fic, `FPM_MANT_W);
		check_eq("g", g, 1'b0);
	endtask

	task automatic flag_case(input logic [7:0] b_val, input logic [7:0] d_val,
		input fpm_bmode_t mode, input logic cin, input fpm_op_t op, input logic mz);
		fpm_flags_t want;
		logic [`FPM_D_W-1:0] s;
		logic [`FPM_D_W-1:0] bb;
		int low;
		prepare(b_val, d_val);
		set_bus(mode, cin);
		s = expect_sum(mode, cin);
		bb = bus_value(mode);
		low = bb[`FPM_EXP_W-1:0] + d_model[`FPM_EXP_W-1:0] + cin;
		want.c = low > 255;
		want.v = ($signed(s) > 127) || ($signed(s) < -128);
		want.m = s[`FPM_D_W-1];
		want.z = (s == 0) || (op >= op_af && mz);
		pulse_align(op, 1'b1, mz);
		check_eq("flags", flags, want);
	endtask

	task automatic test_faults();
		int n;
		pulse_clear();
		// +254 and -256 do not fit in a byte
		prepare(8'h7f, 8'h7f);
		set_bus(bm_true, 1'b0);
		pulse_align(op_mf, 1'b1, 1'b0);
		check_eq("faults", faults, 4'b0100);
		prepare(8'h80, 8'h80);
		set_bus(bm_true, 1'b0);
		pulse_align(op_mf, 1'b1, 1'b0);
		check_eq("faults", faults, 4'b0110);
		pulse_clear();
		// sum of -128 fits, so df raises only fi3
		set_bus(bm_zero, 1'b0);
		pulse_align(op_df, 1'b1, 1'b1);
		check_eq("faults", faults, 4'b1001);
		n = 0;
		while (faults.fi0 && n < 16) begin
			n++;
			@(negedge f2strob);
		end
		if (faults.fi0) begin
			$display("timeout: fi0 pulse never ended");
			abort_run();
		end
		check_eq("fi0_cycles", n, `FPM_FI0_TICKS);
		check_eq("faults", faults, 4'b0001);
		pulse_clear();
		pulse_align(op_df, 1'b0, 1'b1);
		check_eq("flags", flags, 4'h0);
		check_eq("faults", faults, 4'h0);
	endtask

	initial begin
		reset = 1'b1;
		ir = op_ad;
		w = '0;
		b_mode = bm_zero;
		pufa = 1'b0;
		lkb = 1'b0;
		load_d = 1'b0;
		load_b = 1'b0;
		carry_in = 1'b0;
		align = 1'b0;
		shift = 1'b0;
		mant_zero = 1'b0;
		clear_f = 1'b0;
		b_model = '0;
		d_model = '0;
		repeat (10) @(posedge f2strob);
		reset <= 1'b0;
		@(negedge f2strob);
		check_eq("d", d, 10'h0);
		check_eq("fic", fic, 6'h0);
		check_eq("flags", flags, 4'h0);
		check_eq("faults", faults, 4'h0);
		test_load_add();
		test_align();
		test_muldiv();
		flag_case(8'h01, 8'hff, bm_true, 1'b0, op_ad, 1'b0);
		flag_case(8'h00, 8'h85, bm_zero, 1'b0, op_ad, 1'b0);
		flag_case(8'h7f, 8'h01, bm_true, 1'b0, op_ad, 1'b0);
		flag_case(8'h33, 8'h10, bm_ones, 1'b1, op_sd, 1'b0);
		flag_case(8'h05, 8'h09, bm_true, 1'b0, op_af, 1'b1);
		flag_case(8'h05, 8'h09, bm_true, 1'b0, op_ad, 1'b1);
		test_faults();
		if (fpm_inst.chk_inst.fail_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

//--- fpm.f
+incdir+verilog
verilog/fpm_pkg.sv
verilog/fpm_op_decode.sv
verilog/fpm_exp_path.sv
verilog/fpm_shift_count.sv
verilog/fpm_flags.sv
verilog/fpm_faults.sv
verilog/fpm.sv
tb/fpm_chk.sv
tb/fpm_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fpm testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fpm_tb -Mdir obj_dir -f fpm.f

./obj_dir/Vfpm_tb | tee sim.log

if grep -q "PASS: all tests" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
